//--- source/lsu_defines.svh
// Sizes for the load/store unit; LSU_XLEN is fixed at 64 and LSU_RAM_AW must equal log2(LSU_RAM_WORDS)
`ifndef LSU_DEFINES_SVH
`define LSU_DEFINES_SVH

// Data path width in bits
`define LSU_XLEN 64

// RAM depth in double-words, a power of two
`define LSU_RAM_WORDS 256

// Index width into the RAM
`define LSU_RAM_AW 8

`endif

//--- source/lsu_op_pkg.sv
// Core-side request and response types; the core must map funct3 onto these op codes
`include "lsu_defines.svh"

package lsu_op_pkg;

  // Access size and signedness; the write flag in the request picks load or store
  typedef enum logic [2:0] {
    OP_B    = 3'b000,
    OP_BU   = 3'b001,
    OP_H    = 3'b010,
    OP_HU   = 3'b011,
    OP_W    = 3'b100,
    OP_WU   = 3'b101,
    OP_D    = 3'b110,
    OP_NONE = 3'b111
  } mem_op_e;

  typedef enum logic [1:0] {
    ERR_NONE     = 2'd0,
    ERR_MISALIGN = 2'd1,
    ERR_RANGE    = 2'd2,
    ERR_BADOP    = 2'd3
  } lsu_err_e;

  typedef struct packed {
    logic [`LSU_XLEN-1:0] addr;
    logic [`LSU_XLEN-1:0] wdata;
    mem_op_e              op;
    logic                 we;
  } lsu_req_t;

  typedef struct packed {
    logic [`LSU_XLEN-1:0] rdata;
    lsu_err_e             err;
  } lsu_rsp_t;

endpackage

//--- source/lsu_mem_pkg.sv
// Memory-side command and read types for the single-port data RAM; one command per cycle at most
`include "lsu_defines.svh"

package lsu_mem_pkg;

  // One RAM access, write data already placed in its byte lanes
  typedef struct packed {
    logic                   en;
    logic                   we;
    logic [`LSU_RAM_AW-1:0] index;
    logic [`LSU_XLEN/8-1:0] wmask;
    logic [`LSU_XLEN-1:0]   wdata;
  } ram_cmd_t;

  // Raw double-word as stored, not shifted or extended
  typedef logic [`LSU_XLEN-1:0] ram_rdata_t;

endpackage

//--- source/lsu_store_align.sv
// Store lane placement and alignment check; the mask is meaningful only when o_misaligned is low
`timescale 1ns/10ps
`include "lsu_defines.svh"

module lsu_store_align (
  input  logic [2:0]              i_addr_lo,
  input  lsu_op_pkg::mem_op_e     i_op,
  input  logic [`LSU_XLEN-1:0]    i_wdata,
  output logic [`LSU_XLEN-1:0]    o_wdata,
  output logic [`LSU_XLEN/8-1:0]  o_wmask,
  output logic                    o_misaligned
);

  import lsu_op_pkg::*;

  logic [`LSU_XLEN/8-1:0] size_mask;
  logic [3:0]             size_bytes;

  // Byte count of the access, zero for the unused code
  always_comb begin
    case (i_op)
      OP_B, OP_BU: begin
        size_mask  = 8'h01;
        size_bytes = 4'd1;
      end
      OP_H, OP_HU: begin
        size_mask  = 8'h03;
        size_bytes = 4'd2;
      end
      OP_W, OP_WU: begin
        size_mask  = 8'h0f;
        size_bytes = 4'd4;
      end
      OP_D: begin
        size_mask  = 8'hff;
        size_bytes = 4'd8;
      end
      default: begin
        size_mask  = 8'h00;
        size_bytes = 4'd0;
      end
    endcase
  end

  assign o_wdata = i_wdata << {i_addr_lo, 3'b000};

  always_comb begin
    o_wmask = size_mask << i_addr_lo;
    case (i_op)
      OP_H, OP_HU: o_misaligned = i_addr_lo[0];
      OP_W, OP_WU: o_misaligned = |i_addr_lo[1:0];
      OP_D:        o_misaligned = |i_addr_lo;
      default:     o_misaligned = 1'b0;
    endcase

    // An aligned access never runs past the top lane, so no mask bit is lost
    if (i_op != OP_NONE && !o_misaligned) begin
      assert ($countones(o_wmask) == int'(size_bytes))
        else $error("store mask 0x%02h does not cover %0d bytes", o_wmask, size_bytes);
    end
  end

endmodule

//--- source/lsu_load_format.sv
// Load data extraction from one RAM double-word; the address must already be aligned to the size
`timescale 1ns/10ps
`include "lsu_defines.svh"

module lsu_load_format (
  input  logic [2:0]              i_addr_lo,
  input  lsu_op_pkg::mem_op_e     i_op,
  input  lsu_mem_pkg::ram_rdata_t i_rdata,
  output logic [`LSU_XLEN-1:0]    o_data
);

  import lsu_op_pkg::*;

  logic [`LSU_XLEN-1:0] shifted;

  // Addressed byte moves down to lane zero
  assign shifted = i_rdata >> {i_addr_lo, 3'b000};

  always_comb begin
    case (i_op)
      OP_B:    o_data = {{(`LSU_XLEN-8){shifted[7]}}, shifted[7:0]};
      OP_BU:   o_data = {{(`LSU_XLEN-8){1'b0}}, shifted[7:0]};
      OP_H:    o_data = {{(`LSU_XLEN-16){shifted[15]}}, shifted[15:0]};
      OP_HU:   o_data = {{(`LSU_XLEN-16){1'b0}}, shifted[15:0]};
      OP_W:    o_data = {{(`LSU_XLEN-32){shifted[31]}}, shifted[31:0]};
      OP_WU:   o_data = {{(`LSU_XLEN-32){1'b0}}, shifted[31:0]};
      // Full double-word, also for OP_NONE which is gated off upstream
      default: o_data = shifted;
    endcase
  end

endmodule

//--- source/lsu_ctrl.sv
// Handshake FSM for one access in flight; the core must hold i_req stable while valid waits for ready
`timescale 1ns/10ps
`include "lsu_defines.svh"

module lsu_ctrl (
  input  logic                    i_clk,
  input  logic                    i_arst_n,
  input  logic                    i_req_valid,
  output logic                    o_req_ready,
  input  lsu_op_pkg::lsu_req_t    i_req,
  output logic                    o_rsp_valid,
  input  logic                    i_rsp_ready,
  output lsu_op_pkg::lsu_err_e    o_rsp_err,
  output logic                    o_is_load,
  output logic [2:0]              o_addr_lo,
  output lsu_op_pkg::mem_op_e     o_op,
  output logic [`LSU_XLEN-1:0]    o_st_wdata,
  input  logic [`LSU_XLEN-1:0]    i_st_wdata,
  input  logic [`LSU_XLEN/8-1:0]  i_st_wmask,
  input  logic                    i_misaligned,
  output lsu_mem_pkg::ram_cmd_t   o_ram_cmd
);

  import lsu_op_pkg::*;

  typedef enum logic [1:0] {
    S_IDLE,
    S_ISSUE,
    S_RESP
  } state_e;

  state_e   state_q;
  lsu_req_t req_q;
  lsu_err_e err_q;
  lsu_err_e req_err;
  logic     accept;

  assign o_req_ready = (state_q == S_IDLE);
  assign o_rsp_valid = (state_q == S_RESP);
  assign accept      = i_req_valid && o_req_ready;

  // While idle the alignment block sees the live request, so the check is
  // ready at the accepting edge; afterwards it sees the registered copy
  assign o_addr_lo  = (state_q == S_IDLE) ? i_req.addr[2:0] : req_q.addr[2:0];
  assign o_op       = (state_q == S_IDLE) ? i_req.op : req_q.op;
  assign o_st_wdata = (state_q == S_IDLE) ? i_req.wdata : req_q.wdata;

  // Refusal priority is bad op, then misalignment, then range
  always_comb begin
    if (i_req.op == OP_NONE) begin
      req_err = ERR_BADOP;
    end else if (i_misaligned) begin
      req_err = ERR_MISALIGN;
    end else if (|i_req.addr[`LSU_XLEN-1:3+`LSU_RAM_AW]) begin
      req_err = ERR_RANGE;
    end else begin
      req_err = ERR_NONE;
    end
  end

  // --------------------
  // State machine
  // --------------------

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      state_q <= S_IDLE;
    end else begin
      case (state_q)
        S_IDLE: begin
          if (accept) begin
            state_q <= (req_err == ERR_NONE) ? S_ISSUE : S_RESP;
          end
        end
        S_ISSUE: state_q <= S_RESP;
        S_RESP: begin
          if (i_rsp_ready) begin
            state_q <= S_IDLE;
          end
        end
        default: state_q <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge i_clk) begin
    if (accept) begin
      req_q <= i_req;
      err_q <= req_err;
    end
  end

  assign o_rsp_err = err_q;
  assign o_is_load = !req_q.we && (err_q == ERR_NONE);

  // --------------------
  // RAM command
  // --------------------

  always_comb begin
    o_ram_cmd.en    = (state_q == S_ISSUE);
    o_ram_cmd.we    = req_q.we;
    o_ram_cmd.index = req_q.addr[3 +: `LSU_RAM_AW];
    o_ram_cmd.wmask = i_st_wmask;
    o_ram_cmd.wdata = i_st_wdata;
  end

  rsp_hold_a: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    o_rsp_valid && !i_rsp_ready |=> o_rsp_valid && $stable(o_rsp_err));

  ready_xor_valid_a: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    !(o_req_ready && o_rsp_valid));

endmodule

//--- source/data_ram.sv
// Single-port data RAM with one cycle read latency; contents power up undefined and are never reset
`timescale 1ns/10ps
`include "lsu_defines.svh"

module data_ram (
  input  logic                    i_clk,
  input  lsu_mem_pkg::ram_cmd_t   i_cmd,
  output lsu_mem_pkg::ram_rdata_t o_rdata
);

  logic [`LSU_XLEN-1:0] mem [`LSU_RAM_WORDS];

  // Writes touch only the masked bytes; the read register holds between reads
  always_ff @(posedge i_clk) begin
    if (i_cmd.en) begin
      if (i_cmd.we) begin
        for (int b = 0; b < `LSU_XLEN/8; b++) begin
          if (i_cmd.wmask[b]) begin
            mem[i_cmd.index][8*b +: 8] <= i_cmd.wdata[8*b +: 8];
          end
        end
      end else begin
        o_rdata <= mem[i_cmd.index];
      end
    end
  end

  // An empty mask on a write means the controller let a refused store through
  wmask_nonzero_a: assert property (@(posedge i_clk)
    i_cmd.en && i_cmd.we |-> i_cmd.wmask != '0);

endmodule

//--- source/lsu_top.sv
// Load/store unit with its data RAM; accesses must be naturally aligned and inside the RAM range
`timescale 1ns/10ps
`include "lsu_defines.svh"

module lsu_top (
  input  logic                 i_clk,
  input  logic                 i_arst_n,
  input  logic                 i_req_valid,
  output logic                 o_req_ready,
  input  lsu_op_pkg::lsu_req_t i_req,
  output logic                 o_rsp_valid,
  input  logic                 i_rsp_ready,
  output lsu_op_pkg::lsu_rsp_t o_rsp
);

  import lsu_op_pkg::*;
  import lsu_mem_pkg::*;

  lsu_err_e               rsp_err;
  logic                   is_load;
  logic [2:0]             addr_lo;
  mem_op_e                op;
  logic [`LSU_XLEN-1:0]   st_wdata_raw;
  logic [`LSU_XLEN-1:0]   st_wdata_lane;
  logic [`LSU_XLEN/8-1:0] st_wmask;
  logic                   misaligned;
  ram_cmd_t               ram_cmd;
  ram_rdata_t             ram_rdata;
  logic [`LSU_XLEN-1:0]   ld_data;

  lsu_ctrl u_ctrl (
    .i_clk        (i_clk),
    .i_arst_n     (i_arst_n),
    .i_req_valid  (i_req_valid),
    .o_req_ready  (o_req_ready),
    .i_req        (i_req),
    .o_rsp_valid  (o_rsp_valid),
    .i_rsp_ready  (i_rsp_ready),
    .o_rsp_err    (rsp_err),
    .o_is_load    (is_load),
    .o_addr_lo    (addr_lo),
    .o_op         (op),
    .o_st_wdata   (st_wdata_raw),
    .i_st_wdata   (st_wdata_lane),
    .i_st_wmask   (st_wmask),
    .i_misaligned (misaligned),
    .o_ram_cmd    (ram_cmd)
  );

  lsu_store_align u_store_align (
    .i_addr_lo    (addr_lo),
    .i_op         (op),
    .i_wdata      (st_wdata_raw),
    .o_wdata      (st_wdata_lane),
    .o_wmask      (st_wmask),
    .o_misaligned (misaligned)
  );

  data_ram u_ram (
    .i_clk   (i_clk),
    .i_cmd   (ram_cmd),
    .o_rdata (ram_rdata)
  );

  lsu_load_format u_load_format (
    .i_addr_lo (addr_lo),
    .i_op      (op),
    .i_rdata   (ram_rdata),
    .o_data    (ld_data)
  );

  // Stores and refused accesses answer with zero data
  assign o_rsp.rdata = is_load ? ld_data : '0;
  assign o_rsp.err   = rsp_err;

endmodule

//--- test/tb_lsu.sv
// Directed testbench for lsu_top; every RAM word is written through the DUT before any load is checked
`timescale 1ns/10ps
`include "lsu_defines.svh"

module tb_lsu;

  import lsu_op_pkg::*;

  localparam int WAIT_LIMIT = 40;
  localparam int RAM_BYTES  = 8 * `LSU_RAM_WORDS;

  logic        i_clk;
  logic        i_arst_n;
  logic        i_req_valid;
  logic        o_req_ready;
  lsu_req_t    i_req;
  logic        o_rsp_valid;
  logic        i_rsp_ready;
  lsu_rsp_t    o_rsp;
  logic [7:0]  shadow [RAM_BYTES];
  logic [31:0] lcg_state;
  int          errors;
  int          checks;

  lsu_top DUT (.*);

  initial begin
    i_clk = 1'b0;
    forever #10 i_clk = ~i_clk;
  end

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  function automatic int rand_below(input int n);
    return int'(next_rand() >> 16) % n;
  endfunction

  function automatic int access_bytes(input mem_op_e op);
    case (op)
      OP_B, OP_BU: return 1;
      OP_H, OP_HU: return 2;
      OP_W, OP_WU: return 4;
      default:     return 8;
    endcase
  endfunction

  // Little-endian bytes from the shadow, filled with the top bit for the signed ops
  function automatic logic [63:0] expect_load(input mem_op_e op, input int addr);
    logic [63:0] value;
    logic        ext;
    ext = (op == OP_B || op == OP_H || op == OP_W) && shadow[addr + access_bytes(op) - 1][7];
    for (int k = 0; k < 8; k++) begin
      value[8*k +: 8] = (k < access_bytes(op)) ? shadow[addr + k] : {8{ext}};
    end
    return value;
  endfunction

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("[FAIL] %s expected 0x%016h actual 0x%016h", name, expected, actual);
    end
  endtask

  // Edges counts rising edges from the accepting one up to the first valid response
  task automatic do_access(input logic we, input mem_op_e op, input logic [63:0] addr,
                           input logic [63:0] wdata, input int hold,
                           output lsu_rsp_t rsp, output int edges);
    int waited;
    rsp    = '0;
    edges  = 0;
    waited = 0;
    @(negedge i_clk);
    i_req.addr  = addr;
    i_req.wdata = wdata;
    i_req.op    = op;
    i_req.we    = we;
    i_req_valid = 1'b1;
    while (o_req_ready !== 1'b1 && waited < WAIT_LIMIT) begin
      @(negedge i_clk);
      waited++;
    end
    @(negedge i_clk);
    i_req_valid = 1'b0;
    if (waited == WAIT_LIMIT) begin
      errors++;
      $display("Timeout: request ready never rose for address 0x%0h", addr);
    end else begin
      edges  = 1;
      waited = 0;
      while (o_rsp_valid !== 1'b1 && waited < WAIT_LIMIT) begin
        @(negedge i_clk);
        edges++;
        waited++;
      end
      if (waited == WAIT_LIMIT) begin
        errors++;
        $display("Timeout: no response for address 0x%0h", addr);
      end else begin
        rsp = o_rsp;
        for (int c = 0; c < hold; c++) begin
          @(negedge i_clk);
          if (o_rsp_valid !== 1'b1 || o_rsp !== rsp || o_req_ready !== 1'b0) begin
            errors++;
            $display("Response moved while held off at address 0x%0h", addr);
          end
        end
        i_rsp_ready = 1'b1;
        @(negedge i_clk);
        i_rsp_ready = 1'b0;
      end
    end
  endtask

  task automatic access_and_compare(input string name, input logic we, input mem_op_e op,
                                    input int addr, input logic [63:0] wdata);
    lsu_rsp_t rsp;
    int       edges;
    do_access(we, op, 64'(addr), wdata, 0, rsp, edges);
    check_value({name, " err"}, 64'(ERR_NONE), 64'(rsp.err));
    check_value({name, " data"}, we ? 64'd0 : expect_load(op, addr), rsp.rdata);
    for (int k = 0; k < access_bytes(op) && we; k++) begin
      shadow[addr + k] = wdata[8*k +: 8];
    end
  endtask

  task automatic refused_access(input string name, input logic we, input mem_op_e op,
                                input logic [63:0] addr, input lsu_err_e err);
    lsu_rsp_t rsp;
    int       edges;
    do_access(we, op, addr, 64'hFFFF_FFFF_FFFF_FFFF, 0, rsp, edges);
    check_value({name, " err"}, 64'(err), 64'(rsp.err));
    check_value({name, " data"}, 64'd0, rsp.rdata);
  endtask

  // --------------------
  // Directed tests
  // --------------------

  task automatic widths_and_signs();
    mem_op_e op;
    access_and_compare("widths SD", 1'b1, OP_D, 40, 64'h7E57_F00D_8001_C0DE);
    for (int i = 0; i < 7; i++) begin
      op = mem_op_e'(3'(i));
      for (int off = 0; off < 8; off += access_bytes(op)) begin
        access_and_compare($sformatf("widths %s +%0d", op.name(), off), 1'b0, op, 40 + off, '0);
      end
    end
  endtask

  task automatic byte_lane_merging();
    for (int off = 0; off < 8; off++) begin
      access_and_compare("merge SB", 1'b1, OP_B, 72 + off, {next_rand(), next_rand()});
    end
    access_and_compare("merge SH", 1'b1, OP_H, 74, {next_rand(), next_rand()});
    access_and_compare("merge SW", 1'b1, OP_W, 76, {next_rand(), next_rand()});
    access_and_compare("merge LD", 1'b0, OP_D, 72, '0);
  endtask

  task automatic misaligned_access();
    refused_access("misaligned LH", 1'b0, OP_H, 64'd97, ERR_MISALIGN);
    refused_access("misaligned LW", 1'b0, OP_W, 64'd99, ERR_MISALIGN);
    refused_access("misaligned LD", 1'b0, OP_D, 64'd101, ERR_MISALIGN);
    refused_access("misaligned SW", 1'b1, OP_W, 64'd98, ERR_MISALIGN);
    access_and_compare("misaligned LD after", 1'b0, OP_D, 96, '0);
  endtask

  task automatic range_and_bad_op();
    refused_access("range LD", 1'b0, OP_D, 64'(RAM_BYTES), ERR_RANGE);
    refused_access("range SD", 1'b1, OP_D, 64'(RAM_BYTES + 24), ERR_RANGE);
    refused_access("range high SB", 1'b1, OP_B, 64'h8000_0000_0000_0020, ERR_RANGE);
    refused_access("bad op load", 1'b0, OP_NONE, 64'd32, ERR_BADOP);
    refused_access("bad op store", 1'b1, OP_NONE, 64'd32, ERR_BADOP);
    refused_access("bad op over range", 1'b1, OP_NONE, 64'(RAM_BYTES + 1), ERR_BADOP);
    refused_access("misalign over range", 1'b0, OP_H, 64'(RAM_BYTES + 1), ERR_MISALIGN);
    access_and_compare("range LD after", 1'b0, OP_D, 24, '0);
    access_and_compare("bad op LD after", 1'b0, OP_D, 32, '0);
  endtask

  task automatic back_pressure();
    lsu_rsp_t rsp;
    int       edges;
    for (int i = 0; i < 4; i++) begin
      do_access(1'b0, OP_D, 64'(160 + 8 * i), '0, 1 + rand_below(10), rsp, edges);
      check_value("held load data", expect_load(OP_D, 160 + 8 * i), rsp.rdata);
      check_value("held load edges", 64'd2, 64'(edges));
      do_access(1'b0, OP_W, 64'(162 + 8 * i), '0, 1 + rand_below(10), rsp, edges);
      check_value("held refused err", 64'(ERR_MISALIGN), 64'(rsp.err));
      check_value("held refused edges", 64'd1, 64'(edges));
    end
  endtask

  task automatic random_traffic();
    mem_op_e op;
    int      addr;
    for (int n = 0; n < 200; n++) begin
      op   = mem_op_e'(3'(rand_below(7)));
      addr = 8 * rand_below(`LSU_RAM_WORDS) + (rand_below(8) / access_bytes(op)) * access_bytes(op);
      access_and_compare($sformatf("random %0d %s", n, op.name()), rand_below(2) == 1, op, addr,
                         {next_rand(), next_rand()});
    end
  endtask

  initial begin
    errors      = 0;
    checks      = 0;
    lcg_state   = 32'd12;
    i_arst_n    = 1'b0;
    i_req_valid = 1'b0;
    i_req       = '0;
    i_rsp_ready = 1'b0;
    repeat (8) @(posedge i_clk);
    @(negedge i_clk);
    i_arst_n = 1'b1;
    check_value("reset req ready", 64'd1, 64'(o_req_ready));
    check_value("reset rsp valid", 64'd0, 64'(o_rsp_valid));
    // Known contents in every word, so any later load has a shadow value
    for (int w = 0; w < `LSU_RAM_WORDS; w++) begin
      access_and_compare("fill SD", 1'b1, OP_D, 8 * w,
                         {32'(w) * 32'h9E37_79B9, 32'(w) ^ 32'hA5A5_0000});
    end
    widths_and_signs();
    byte_lane_merging();
    misaligned_access();
    range_and_bad_op();
    back_pressure();
    random_traffic();
    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

//--- vlog.f
+incdir+source
source/lsu_op_pkg.sv
source/lsu_mem_pkg.sv
source/lsu_store_align.sv
source/lsu_load_format.sv
source/lsu_ctrl.sv
source/data_ram.sv
source/lsu_top.sv
test/tb_lsu.sv

//--- Makefile
TOP       ?= tb_lsu
VERILATOR ?= verilator
FLAGS     ?= --assert --timing
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "TEST OK"

clean:
	rm -rf $(OBJ_DIR)
